/* list.f */
spi_frame_pkg.sv
spi_ctrl_pkg.sv
spi_cmd_if.sv
spi_cmd_arbiter.sv
spi_master.sv
spi_host_top.sv
tb_spi_slave.sv
tb_spi_host.sv

/* run.sh */
#!/bin/sh
# Build and run the SPI host testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_spi_host -f list.f

./obj_dir/Vtb_spi_host > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
  exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0

/* tb_spi_host.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_spi_host;
  import spi_frame_pkg::*;

  localparam int n_rows  = 20;
  localparam int tmo_cyc = 400;

  logic   clk;
  logic   rst_n;
  cmd_t   p0_cmd;
  logic   p0_cmd_vld;
  logic   p0_cmd_rdy;
  logic   p0_read_vld;
  rdata_t p0_read_data;
  cmd_t   p1_cmd;
  logic   p1_cmd_vld;
  logic   p1_cmd_rdy;
  logic   p1_read_vld;
  rdata_t p1_read_data;
  logic   sclk;
  logic   cs;
  logic   mosi;
  logic   miso;
  logic   frame_error;

  // Stimulus table. Port 2 issues two reads at once, p0 at addr, p1 at data[2:0].
  int         row_port [0:n_rows-1];
  logic       row_wr   [0:n_rows-1];
  logic [2:0] row_addr [0:n_rows-1];
  logic [7:0] row_data [0:n_rows-1];
  logic       row_rnd  [0:n_rows-1];
  int         n_added;

  logic [7:0]  exp_regs [0:7];  // Reference register file.
  logic        exp_turn;
  logic [31:0] lfsr;
  int          err;
  int          pass_cnt;
  int          fail_cnt;
  logic        timed_out;

  spi_host_top dut0 (.*);

  tb_spi_slave slave0 (
    .rst_n       (rst_n),
    .sclk        (sclk),
    .cs          (cs),
    .mosi        (mosi),
    .miso        (miso),
    .frame_error (frame_error)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ##################################################
  // Helpers
  // ##################################################

  task automatic add_row(input int port, input logic wr, input logic [2:0] addr,
                         input logic [7:0] data, input logic rnd);
    row_port[n_added] = port;
    row_wr[n_added]   = wr;
    row_addr[n_added] = addr;
    row_data[n_added] = data;
    row_rnd[n_added]  = rnd;
    n_added++;
  endtask

  // Taps 32, 22, 2, 1; one step per bit taken.
  function automatic logic [7:0] rand_byte();
    logic [7:0] b;
    b = '0;
    for (int i = 0; i < 8; i++)
    begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      b    = {b[6:0], lfsr[0]};
    end
    return b;
  endfunction

  task automatic check_bit(input string name, input logic got, input logic exp);
    assert (got === exp)
    else
    begin
      $display("FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
      err++;
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    assert (got === exp)
    else
    begin
      $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
      err++;
    end
  endtask

  function automatic logic rdy_of(input int port);
    return (port == 0) ? p0_cmd_rdy : p1_cmd_rdy;
  endfunction

  task automatic drive_port(input int port, input logic vld, input cmd_t cmd);
    if (port == 0)
    begin
      p0_cmd_vld = vld;
      p0_cmd     = cmd;
    end
    else
    begin
      p1_cmd_vld = vld;
      p1_cmd     = cmd;
    end
  endtask

  // Waits at falling edges until the port sees cmd_rdy.
  task automatic wait_rdy(input int port);
    int n;
    n = 0;
    @(negedge clk);
    while (!rdy_of(port) && n < tmo_cyc)
    begin
      @(negedge clk);
      n++;
    end
    if (!rdy_of(port))
    begin
      $display("Timeout: port %0d never saw cmd_rdy", port);
      err++;
      timed_out = 1'b1;
    end
  endtask

  task automatic wait_read(input int port, input logic [7:0] exp);
    int n;
    n = 0;
    @(negedge clk);
    while (!p0_read_vld && !p1_read_vld && n < tmo_cyc)
    begin
      @(negedge clk);
      n++;
    end
    if (!p0_read_vld && !p1_read_vld)
    begin
      $display("Timeout: no read_vld for port %0d", port);
      err++;
      timed_out = 1'b1;
    end
    else if (port == 0)
    begin
      check_bit("p0_read_vld", p0_read_vld, 1'b1);
      check_bit("p1_read_vld", p1_read_vld, 1'b0);
      check_byte("p0_read_data", p0_read_data, exp);
    end
    else
    begin
      check_bit("p1_read_vld", p1_read_vld, 1'b1);
      check_bit("p0_read_vld", p0_read_vld, 1'b0);
      check_byte("p1_read_data", p1_read_data, exp);
    end
  endtask

  // Single command through one port, turn flips away from it.
  task automatic single_cmd(input int port, input logic wr, input logic [2:0] addr,
                            input logic [7:0] data);
    @(posedge clk);
    #2 drive_port(port, 1'b1, {wr, addr, data});
    wait_rdy(port);
    if (!timed_out)
    begin
      @(posedge clk);
      #2 drive_port(port, 1'b0, '0);
      exp_turn = (port == 0);
      if (wr)
        exp_regs[addr] = data;
      else
        wait_read(port, exp_regs[addr]);
    end
  endtask

  task automatic dual_read(input logic [2:0] addr0, input logic [2:0] addr1);
    int win;
    int lose;
    win  = exp_turn ? 1 : 0;  // Tie goes to the port named by turn.
    lose = 1 - win;
    @(posedge clk);
    #2;
    drive_port(0, 1'b1, {1'b0, addr0, 8'h00});
    drive_port(1, 1'b1, {1'b0, addr1, 8'h00});
    @(negedge clk);
    check_bit("p0_cmd_rdy", p0_cmd_rdy, win == 0);
    check_bit("p1_cmd_rdy", p1_cmd_rdy, win == 1);
    @(posedge clk);
    #2 drive_port(win, 1'b0, '0);
    exp_turn = (win == 0);
    wait_read(win, exp_regs[(win == 0) ? addr0 : addr1]);
    if (!timed_out)
      wait_rdy(lose);
    if (!timed_out)
    begin
      @(posedge clk);
      #2 drive_port(lose, 1'b0, '0);
      exp_turn = (lose == 0);
      wait_read(lose, exp_regs[(lose == 0) ? addr0 : addr1]);
    end
  endtask

  // cs low with a ready port means a frame while the master is idle.
  always @(negedge clk)
  begin
    if (rst_n)
    begin
      assert (cs || !(p0_cmd_rdy || p1_cmd_rdy))
      else
      begin
        $display("Chip select is low while the master accepts commands at t=%0t", $time);
        err++;
      end
    end
  end

  // ##################################################
  // Main sequence
  // ##################################################

  initial
  begin
    int         err_before;
    logic [7:0] d;
    rst_n      = 1'b0;
    p0_cmd     = '0;
    p0_cmd_vld = 1'b0;
    p1_cmd     = '0;
    p1_cmd_vld = 1'b0;
    lfsr       = 32'h860477d9;
    err        = 0;
    pass_cnt   = 0;
    fail_cnt   = 0;
    timed_out  = 1'b0;
    exp_turn   = 1'b0;
    n_added    = 0;
    for (int i = 0; i < 8; i++)
      exp_regs[i] = 8'(8'hA0 + i);

    add_row(0, 1'b0, 3'd5, 8'h00, 1'b0);  // Unwritten register.
    for (int i = 0; i < 8; i++)
      add_row(i % 2, 1'b1, 3'(i), 8'h00, 1'b1);
    for (int i = 0; i < 8; i++)
      add_row((i + 1) % 2, 1'b0, 3'(i), 8'h00, 1'b0);
    add_row(2, 1'b0, 3'd2, 8'h06, 1'b0);
    add_row(1, 1'b1, 3'd3, 8'h5A, 1'b0);
    add_row(0, 1'b0, 3'd3, 8'h00, 1'b0);

    repeat (10) @(posedge clk);
    #2 rst_n = 1'b1;

    @(negedge clk);
    err_before = err;
    check_bit("cs", cs, 1'b1);
    check_bit("sclk", sclk, 1'b0);
    check_bit("mosi", mosi, 1'b0);
    check_bit("p0_read_vld", p0_read_vld, 1'b0);
    check_bit("p1_read_vld", p1_read_vld, 1'b0);
    check_bit("p0_cmd_rdy", p0_cmd_rdy, 1'b1);
    check_bit("p1_cmd_rdy", p1_cmd_rdy, 1'b1);
    if (err == err_before)
      pass_cnt++;
    else
      fail_cnt++;
    $display("reset state: %s", (err == err_before) ? "ok" : "FAIL");

    for (int r = 0; r < n_added; r++)
    begin
      if (!timed_out)
      begin
        err_before = err;
        d = row_data[r];
        if (row_rnd[r])
          d = rand_byte();
        if (row_port[r] == 2)
          dual_read(row_addr[r], row_data[r][2:0]);
        else
          single_cmd(row_port[r], row_wr[r], row_addr[r], d);
        if (err == err_before)
          pass_cnt++;
        else
          fail_cnt++;
        $display("row %0d port %0d %s addr %0d: %s", r, row_port[r],
                 row_wr[r] ? "write" : "read", row_addr[r],
                 (err == err_before) ? "ok" : "FAIL");
      end
    end

    check_bit("frame_error", frame_error, 1'b0);
    if (frame_error)
      fail_cnt++;
    $display("Tests: %0d passed, %0d failed, %0d errors", pass_cnt, fail_cnt, err);
    if (err == 0 && fail_cnt == 0 && !timed_out)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* tb_spi_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_spi_slave (
  input  logic rst_n,
  input  logic sclk,
  input  logic cs,
  input  logic mosi,
  output logic miso,
  output logic frame_error
);
  import spi_frame_pkg::*;

  logic [7:0] regs [0:7];
  cmd_t       rx_cmd;
  rdata_t     tx_byte;
  int         bit_cnt;   // Bits seen in the current cs-low window.
  int         exp_len;

  // ##################################################
  // Command capture and frame length check
  // ##################################################

  always @(posedge sclk or posedge cs or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < 8; i++)
        regs[i] = 8'(8'hA0 + i);
      rx_cmd      = '0;
      tx_byte     = '0;
      bit_cnt     = 0;
      frame_error = 1'b0;
    end
    else if (cs)
    begin
      if (bit_cnt != 0)
      begin
        exp_len = rx_cmd[rw_bit] ? w_frame_bits : r_frame_bits;
        if (bit_cnt != exp_len)
          frame_error = 1'b1;  // Sticky.
      end
      bit_cnt = 0;
    end
    else
    begin
      if (bit_cnt < cmd_width)
        rx_cmd = {rx_cmd[cmd_width-2:0], mosi};
      bit_cnt = bit_cnt + 1;
      if (bit_cnt == cmd_width)
      begin
        if (rx_cmd[rw_bit])
          regs[rx_cmd[rw_bit-1:addr_lsb]] = rx_cmd[read_width-1:0];
        else
          tx_byte = regs[rx_cmd[rw_bit-1:addr_lsb]];
      end
    end
  end

  // Read byte goes out MSB first, moving on falling sclk.
  always @(negedge sclk or negedge rst_n)
  begin
    if (!rst_n)
      miso <= 1'b0;
    else if (!cs && !rx_cmd[rw_bit] && bit_cnt >= cmd_width && bit_cnt < r_frame_bits)
      miso <= tx_byte[3'(r_frame_bits - 1 - bit_cnt)];
  end

endmodule

`default_nettype wire

/* spi_host_top.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_host_top (
  input  logic                  clk,
  input  logic                  rst_n,
  // Requester 0.
  input  spi_frame_pkg::cmd_t   p0_cmd,
  input  logic                  p0_cmd_vld,
  output logic                  p0_cmd_rdy,
  output logic                  p0_read_vld,
  output spi_frame_pkg::rdata_t p0_read_data,
  // Requester 1.
  input  spi_frame_pkg::cmd_t   p1_cmd,
  input  logic                  p1_cmd_vld,
  output logic                  p1_cmd_rdy,
  output logic                  p1_read_vld,
  output spi_frame_pkg::rdata_t p1_read_data,
  // SPI link.
  output logic                  sclk,
  output logic                  cs,
  output logic                  mosi,
  input  logic                  miso
);

  spi_cmd_if req0 ();
  spi_cmd_if req1 ();
  spi_cmd_if mst ();

  // ##################################################
  // Port mapping
  // ##################################################

  assign req0.cmd      = p0_cmd;
  assign req0.cmd_vld  = p0_cmd_vld;
  assign p0_cmd_rdy    = req0.cmd_rdy;
  assign p0_read_vld   = req0.read_vld;
  assign p0_read_data  = req0.read_data;

  assign req1.cmd      = p1_cmd;
  assign req1.cmd_vld  = p1_cmd_vld;
  assign p1_cmd_rdy    = req1.cmd_rdy;
  assign p1_read_vld   = req1.read_vld;
  assign p1_read_data  = req1.read_data;

  // Two requesters share one frame engine.
  spi_cmd_arbiter arb0 (
    .clk   (clk),
    .rst_n (rst_n),
    .req0  (req0),
    .req1  (req1),
    .mst   (mst)
  );

  spi_master mst0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_port (mst),
    .sclk     (sclk),
    .cs       (cs),
    .mosi     (mosi),
    .miso     (miso)
  );

endmodule

`default_nettype wire

/* spi_master.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_master (
  input  logic       clk,
  input  logic       rst_n,
  spi_cmd_if.server  cmd_port,
  output logic       sclk,
  output logic       cs,
  output logic       mosi,
  input  logic       miso
);
  import spi_frame_pkg::*;
  import spi_ctrl_pkg::*;

  master_state_t            state;
  master_state_t            state_nxt;
  cmd_t                     tx_shift;   // Outgoing frame, MSB at the top.
  rdata_t                   rx_shift;   // Incoming byte.
  logic [div_cnt_width-1:0] div_cnt;    // Phase within one SCLK period.
  logic [bit_cnt_width-1:0] bit_cnt;    // Bit index within the frame.
  logic                     shifting;
  logic                     bit_end;
  logic                     sclk_rise;
  logic                     frame_last;
  logic                     read_vld_q;

  // ##################################################
  // Frame timing
  // ##################################################

  assign shifting = state inside {w_start, w_data, r_start, wr_data, rr_data};

  assign bit_end   = shifting && (div_cnt == div_cnt_width'(sclk_div - 1));
  assign sclk_rise = shifting && (div_cnt == div_cnt_width'(half_div - 1));

  // Last cycle of the final bit period.
  assign frame_last = bit_end &&
                      (((state == w_data) && (bit_cnt == bit_cnt_width'(w_frame_bits - 1))) ||
                       ((state == rr_data) && (bit_cnt == bit_cnt_width'(r_frame_bits - 1))));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      div_cnt <= '0;
      bit_cnt <= '0;
    end
    else if (!shifting)
    begin
      div_cnt <= '0;
      bit_cnt <= '0;
    end
    else if (bit_end)
    begin
      div_cnt <= '0;
      bit_cnt <= bit_cnt + 1'b1;
    end
    else
      div_cnt <= div_cnt + 1'b1;
  end

  // ##################################################
  // State machine
  // ##################################################

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= idle;
    else
      state <= state_nxt;
  end

  always_comb
  begin
    state_nxt = state;
    case (state)
      idle:
        if (cmd_port.cmd_vld)
          state_nxt = judge;
      judge:
        if (tx_shift[rw_bit])
          state_nxt = w_start;
        else
          state_nxt = r_start;
      w_start:
        if (bit_end)
          state_nxt = w_data;
      w_data:
        if (frame_last)
          state_nxt = w_finish;
      r_start:
        if (bit_end)
          state_nxt = wr_data;
      wr_data:
        if (bit_end && (bit_cnt == bit_cnt_width'(cmd_width - 1)))
          state_nxt = rr_data;  // Command sent, byte comes back next.
      rr_data:
        if (frame_last)
          state_nxt = r_finish;
      w_finish,
      r_finish:
        state_nxt = idle;
      default:
        state_nxt = idle;
    endcase
  end

  assign cmd_port.cmd_rdy = (state == idle);

  // ##################################################
  // Serial pins
  // ##################################################

  // Mode 0: mosi moves while sclk is low, sclk rises at mid-bit.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cs         <= 1'b1;
      sclk       <= 1'b0;
      mosi       <= 1'b0;
      read_vld_q <= 1'b0;
    end
    else
    begin
      read_vld_q <= frame_last && (state == rr_data);
      if (state == judge)
      begin
        cs   <= 1'b0;
        mosi <= tx_shift[cmd_width-1];  // First bit is ready before the first edge.
      end
      else if (frame_last)
      begin
        cs   <= 1'b1;
        sclk <= 1'b0;
        mosi <= 1'b0;
      end
      else if (bit_end)
      begin
        sclk <= 1'b0;
        mosi <= tx_shift[cmd_width-2];
      end
      else if (sclk_rise)
        sclk <= 1'b1;
    end
  end

  // Command and read byte shifters.
  always_ff @(posedge clk)
  begin
    if (cmd_port.cmd_vld && cmd_port.cmd_rdy)
      tx_shift <= cmd_port.cmd;
    else if (bit_end)
      tx_shift <= {tx_shift[cmd_width-2:0], 1'b0};  // Zeros follow the command.
    if (sclk_rise && (state == rr_data))
      rx_shift <= {rx_shift[read_width-2:0], miso};  // MSB first.
  end

  assign cmd_port.read_vld  = read_vld_q;
  assign cmd_port.read_data = rx_shift;

endmodule

`default_nettype wire

/* spi_cmd_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_cmd_arbiter (
  input  logic          clk,
  input  logic          rst_n,
  spi_cmd_if.server     req0,
  spi_cmd_if.server     req1,
  spi_cmd_if.requester  mst
);
  import spi_frame_pkg::*;
  import spi_ctrl_pkg::*;

  turn_t turn;
  logic  grant_p1;     // Selected port, 0 or 1.
  logic  gnt0;
  logic  gnt1;
  logic  accept;
  logic  read_owner;   // Port that issued the read in flight.
  logic  rsp0_vld;
  logic  rsp1_vld;

  // ##################################################
  // Request path
  // ##################################################

  always_comb
  begin
    if (req0.cmd_vld && req1.cmd_vld)
      grant_p1 = (turn == turn_p1);  // Tie goes to the port named by turn.
    else if (req1.cmd_vld)
      grant_p1 = 1'b1;
    else
      grant_p1 = 1'b0;
  end

  assign gnt0 = req0.cmd_vld && !grant_p1;
  assign gnt1 = req1.cmd_vld && grant_p1;

  assign mst.cmd     = grant_p1 ? req1.cmd : req0.cmd;
  assign mst.cmd_vld = grant_p1 ? req1.cmd_vld : req0.cmd_vld;

  // A port stalls only while the master is busy or the other port holds the grant.
  assign req0.cmd_rdy = mst.cmd_rdy && !gnt1;
  assign req1.cmd_rdy = mst.cmd_rdy && !gnt0;

  assign accept = mst.cmd_vld && mst.cmd_rdy;

  // Priority and read ownership.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      turn       <= turn_p0;
      read_owner <= 1'b0;
    end
    else if (accept)
    begin
      turn <= grant_p1 ? turn_p0 : turn_p1;  // Other port goes first next time.
      if (!mst.cmd[rw_bit])
        read_owner <= grant_p1;
    end
  end

  // ##################################################
  // Response path
  // ##################################################

  assign rsp0_vld = mst.read_vld && !read_owner;
  assign rsp1_vld = mst.read_vld && read_owner;

  assign req0.read_vld  = rsp0_vld;
  assign req1.read_vld  = rsp1_vld;
  assign req0.read_data = rsp0_vld ? mst.read_data : '0;  // Only the issuer sees data.
  assign req1.read_data = rsp1_vld ? mst.read_data : '0;

endmodule

`default_nettype wire

/* spi_cmd_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface spi_cmd_if;
  import spi_frame_pkg::*;

  cmd_t   cmd;        // Command word.
  logic   cmd_vld;
  logic   cmd_rdy;
  logic   read_vld;   // One-cycle pulse.
  rdata_t read_data;

  // Side that issues commands.
  modport requester (
    output cmd,
    output cmd_vld,
    input  cmd_rdy,
    input  read_vld,
    input  read_data
  );

  // Side that accepts commands and returns read bytes.
  modport server (
    input  cmd,
    input  cmd_vld,
    output cmd_rdy,
    output read_vld,
    output read_data
  );

endinterface

`default_nettype wire

/* spi_ctrl_pkg.sv */
`default_nettype none

package spi_ctrl_pkg;

  // ##################################################
  // Controller states
  // ##################################################

  // Frame engine. The *_start states carry the first bit of the frame.
  typedef enum logic [3:0] {
    idle,
    judge,     // Branch on the direction bit.
    w_start,
    w_data,
    w_finish,
    r_start,
    wr_data,   // Command bits of a read.
    rr_data,   // Returned byte of a read.
    r_finish
  } master_state_t;

  // Round-robin pointer, names the port that wins a tie.
  typedef enum logic {
    turn_p0,
    turn_p1
  } turn_t;

endpackage

`default_nettype wire

/* spi_frame_pkg.sv */
`default_nettype none

package spi_frame_pkg;

  // ##################################################
  // Frame geometry
  // ##################################################

  localparam int cmd_width  = 12;  // Command word, shifted MSB first.
  localparam int read_width = 8;   // Byte returned by a read.
  localparam int addr_width = 3;

  localparam int w_frame_bits = cmd_width;               // Bits per write frame.
  localparam int r_frame_bits = cmd_width + read_width;  // Bits per read frame.

  // Command word fields.
  localparam int rw_bit   = 11;                   // 1 selects a write.
  localparam int addr_lsb = rw_bit - addr_width;  // Data byte sits below the address.

  // ##################################################
  // SCLK timing
  // ##################################################

  localparam int sclk_div = 4;              // clk cycles per SCLK period.
  localparam int half_div = sclk_div / 2;   // SCLK rises after this many cycles.

  localparam int div_cnt_width = $clog2(sclk_div);
  localparam int bit_cnt_width = $clog2(r_frame_bits);

  // Payload types.
  typedef logic [cmd_width-1:0]  cmd_t;
  typedef logic [read_width-1:0] rdata_t;

endpackage

`default_nettype wire
